// File: sim.f
cpu_pkg.sv
muxs.sv
decoder.sv
alu.sv
reg_file.sv
cpu_core.sv
cpu_core_asserts.sv
tb_cpu_core.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert --top-module tb_cpu_core -f sim.f \
	&& ./obj_dir/Vtb_cpu_core +verilator+error+limit+100 | tee /dev/stderr \
	| grep -q "Finished with no errors" && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// File: tb_cpu_core.sv
`default_nettype none

module tb_cpu_core;

	import cpu_pkg::*;

	localparam int NUM_INSTR = 2000;
	localparam int TIMEOUT = NUM_INSTR * 10 * 3;
	localparam logic [5:0] UNKNOWN_OPS [4] = '{6'h05, 6'h13, 6'h2a, 6'h3f};
	localparam logic [5:0] OP_TABLE [16] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
		OP_SLLI, OP_ADDI, OP_ORI, OP_MOVI, OP_LWI, OP_SWI, OP_LW, OP_LWI, OP_SWI,
		OP_BEQ, OP_J};

	logic clk = 1'b0;
	logic rst_n;
	word_t instr;
	logic instr_valid;
	word_t mem_rdata;
	pc_t pc;
	word_t mem_addr;
	word_t mem_wdata;
	logic mem_read;
	logic mem_write;
	logic ret_valid;
	reg_idx_t ret_reg;
	word_t ret_data;

	logic [15:0] lfsr = 16'd86;
	word_t model_regs [32];
	pc_t model_pc;
	word_t mem [word_t];
	int mem_gen = 0;
	int issued = 0;

	cpu_core u_cpu_core (.*);

	always #5 clk = ~clk;

	// ========================================
	// memory and random source
	// ========================================
	function automatic word_t load_word(word_t addr, int gen);
		return mem.exists(addr) ? mem[addr] : ~addr; // gen bumps on each store.
	endfunction

	assign mem_rdata = load_word(mem_addr, mem_gen);

	function automatic logic next_bit();
		logic fb;
		fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function automatic word_t random_bits(int n);
		word_t v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], next_bit()};
		end
		return v;
	endfunction

	function automatic word_t make_instr();
		logic [5:0] op;
		word_t w;
		if (random_bits(4) == '0) begin
			op = UNKNOWN_OPS[2'(random_bits(2))];
		end else begin
			op = OP_TABLE[4'(random_bits(4))];
		end
		w = random_bits(26);
		w[31:26] = op;
		case (op)
			OP_LWI, OP_SWI: begin
				w[20:16] = 5'(random_bits(2)); // few bases so loads hit stores.
				w[14:0] = 15'(random_bits(4));
			end
			OP_LW: begin
				w[20:16] = 5'(random_bits(2));
				w[15:11] = 5'(random_bits(2));
			end
			OP_BEQ: begin
				if (next_bit()) begin
					w[25:21] = w[20:16];
				end
				w[7:0] = {3'b000, 4'(random_bits(4)), 1'b0};
			end
			OP_J: begin
				w[7:0] = {3'b000, 4'(random_bits(4)), 1'b0}; // keeps pc word aligned.
			end
			default: begin
			end
		endcase
		return w;
	endfunction

	// ========================================
	// compare tasks
	// ========================================
	task automatic abort_run(string why);
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic check_pc(string name, pc_t got, pc_t exp);
		if (got !== exp) begin
			abort_run($sformatf("ERR %0t %s got %h expected %h", $time, name, got, exp));
		end
	endtask

	task automatic check_word(string name, word_t got, word_t exp);
		if (got !== exp) begin
			abort_run($sformatf("ERR %0t %s got %h expected %h", $time, name, got, exp));
		end
	endtask

	task automatic check_reg(string name, reg_idx_t got, reg_idx_t exp);
		if (got !== exp) begin
			abort_run($sformatf("ERR %0t %s got %0d expected %0d", $time, name, got, exp));
		end
	endtask

	task automatic check_flag(string name, logic got, logic exp);
		if (got !== exp) begin
			abort_run($sformatf("ERR %0t %s got %b expected %b", $time, name, got, exp));
		end
	endtask

	task automatic check_cycle();
		logic [5:0] op;
		reg_idx_t rt;
		word_t a, b, t;
		word_t imm15_se;
		word_t addr;
		word_t res;
		logic wr;
		pc_t next;
		if (u_cpu_core.u_cpu_core_asserts.failures != 0) begin
			abort_run("an assertion on the core failed");
		end
		check_pc("pc", pc, model_pc);
		if (!instr_valid) begin
			check_flag("ret_valid", ret_valid, 1'b0);
			check_flag("mem_read", mem_read, 1'b0);
			check_flag("mem_write", mem_write, 1'b0);
			return;
		end
		op = instr[31:26];
		rt = instr[25:21];
		a = model_regs[instr[20:16]];
		b = model_regs[instr[15:11]];
		t = model_regs[rt];
		imm15_se = {{17{instr[14]}}, instr[14:0]};
		wr = 1'b1;
		res = '0;
		addr = a + (imm15_se << 2);
		next = model_pc + 10'd4;
		case (op)
			OP_ADD: res = a + b;
			OP_SUB: res = a - b;
			OP_AND: res = a & b;
			OP_OR: res = a | b;
			OP_XOR: res = a ^ b;
			OP_SLLI: res = a << instr[14:10];
			OP_ADDI: res = a + imm15_se;
			OP_ORI: res = a | {17'b0, instr[14:0]};
			OP_MOVI: res = {{12{instr[19]}}, instr[19:0]};
			OP_LWI: res = load_word(addr, mem_gen);
			OP_LW: begin
				addr = a + (b << instr[9:8]);
				res = load_word(addr, mem_gen);
			end
			OP_BEQ: begin
				wr = 1'b0;
				if (a == t) begin
					next = model_pc + {instr[13], instr[7:0], 1'b0};
				end
			end
			OP_J: begin
				wr = 1'b0;
				next = model_pc + {instr[23], instr[7:0], 1'b0};
			end
			default: wr = 1'b0; // swi and unknown opcodes.
		endcase
		check_flag("ret_valid", ret_valid, wr);
		if (wr) begin
			check_reg("ret_reg", ret_reg, rt);
			check_word("ret_data", ret_data, res);
		end
		check_flag("mem_read", mem_read, op == OP_LWI || op == OP_LW);
		check_flag("mem_write", mem_write, op == OP_SWI);
		if (op == OP_LWI || op == OP_LW || op == OP_SWI) begin
			check_word("mem_addr", mem_addr, addr);
		end
		if (op == OP_SWI) begin
			check_word("mem_wdata", mem_wdata, t);
			mem[addr] = t;
			mem_gen++;
		end
		if (wr && rt != 5'd0) begin
			model_regs[rt] = res;
		end
		model_pc = next;
	endtask

	// ========================================
	// stimulus and watchdog
	// ========================================
	initial begin
		rst_n = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		model_pc = '0;
		for (int i = 0; i < 32; i++) begin
			model_regs[i] = '0;
		end
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		while (issued < NUM_INSTR) begin
			@(posedge clk);
			if (random_bits(2) != '0) begin
				instr_valid <= 1'b1;
				instr <= make_instr();
				issued++;
			end else begin
				instr_valid <= 1'b0;
				instr <= random_bits(32); // ignored while idle.
			end
			@(negedge clk);
			check_cycle();
		end
		@(posedge clk);
		instr_valid <= 1'b0;
		@(negedge clk);
		check_cycle();
		if (u_cpu_core.u_cpu_core_asserts.failures == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

	initial begin
		#(TIMEOUT);
		abort_run("timeout, the core run did not complete in the expected time");
	end

endmodule

`default_nettype wire

// File: cpu_core_asserts.sv
`default_nettype none

module cpu_core_asserts (
	input wire logic clk,
	input wire logic rst_n,
	input wire cpu_pkg::pc_t pc,
	input wire logic mem_read,
	input wire logic mem_write,
	input wire logic ret_valid
);

	int failures = 0;

	a_mem_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(mem_read && mem_write))
		else begin
			$error("mem_read and mem_write high together");
			failures++;
		end

	a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
		else begin
			$error("pc not word aligned");
			failures++;
		end

	// a retiring instruction is accepted and steps the pc by one word.
	a_ret_steps_pc: assert property (@(posedge clk) disable iff (!rst_n)
		ret_valid |=> pc == $past(pc) + 10'd4)
		else begin
			$error("retire without a sequential pc step");
			failures++;
		end

endmodule

bind cpu_core cpu_core_asserts u_cpu_core_asserts (.*);

`default_nettype wire

// File: cpu_core.sv
`default_nettype none

module cpu_core (
	input wire logic clk,
	input wire logic rst_n,
	input wire cpu_pkg::word_t instr,
	input wire logic instr_valid,
	input wire cpu_pkg::word_t mem_rdata,
	output cpu_pkg::pc_t pc,
	output cpu_pkg::word_t mem_addr,
	output cpu_pkg::word_t mem_wdata,
	output logic mem_read,
	output logic mem_write,
	output logic ret_valid,
	output cpu_pkg::reg_idx_t ret_reg,
	output cpu_pkg::word_t ret_data
);

	import cpu_pkg::*;

	ctrl_t ctrl;
	reg_idx_t rt;
	reg_idx_t ra;
	reg_idx_t rb;
	word_t ra_data;
	word_t rb_data;
	word_t rt_data;
	word_t src2;
	word_t alu_result;
	word_t wb_data;
	logic alu_zero;
	sel_pc_t sel_pc;
	pc_t next_pc;

	// ========================================
	// datapath
	// ========================================
	decoder u_decoder (
		.instr (instr),
		.ctrl  (ctrl),
		.rt    (rt),
		.ra    (ra),
		.rb    (rb)
	);

	reg_file u_reg_file (
		.clk     (clk),
		.rst_n   (rst_n),
		.we      (instr_valid & ctrl.reg_write),
		.wa      (rt),
		.ra_idx  (ra),
		.rb_idx  (rb),
		.rt_idx  (rt),
		.wd      (wb_data),
		.ra_data (ra_data),
		.rb_data (rb_data),
		.rt_data (rt_data)
	);

	alu u_alu (
		.a      (ra_data),
		.b      (src2),
		.op     (ctrl.alu_op),
		.result (alu_result),
		.zero   (alu_zero)
	);

	// not-taken branch falls back to sequential.
	assign sel_pc = (ctrl.branch && !alu_zero) ? SEL_PC_SEQ : ctrl.sel_pc;

	muxs u_muxs (
		.current_pc         (pc),
		.sub_op_sv          (instr[SV_HI:SV_LO]),
		.reg_rb_data        (rb_data),
		.reg_rt_data        (rt_data),
		.mem_read_data      (mem_rdata),
		.alu_output         (alu_result),
		.imm_5bit           (instr[IMM5_HI:IMM5_LO]),
		.imm_14bit          (instr[IMM14_HI:0]),
		.imm_15bit          (instr[IMM15_HI:0]),
		.imm_20bit          (instr[IMM20_HI:0]),
		.imm_24bit          (instr[IMM24_HI:0]),
		.select_pc          (sel_pc),
		.select_alu_src2    (ctrl.sel_src2),
		.select_imm_extend  (ctrl.sel_ext),
		.select_write_reg   (ctrl.sel_wb),
		.next_pc            (next_pc),
		.output_imm_reg_mux (src2),
		.write_reg_data     (wb_data)
	);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (instr_valid) begin
			pc <= next_pc; // holds while idle.
		end
	end

	// ========================================
	// memory and retire ports
	// ========================================
	assign mem_addr = alu_result;
	assign mem_wdata = rt_data;
	assign mem_read = instr_valid & ctrl.mem_read;
	assign mem_write = instr_valid & ctrl.mem_write;
	assign ret_valid = instr_valid & ctrl.reg_write;
	assign ret_reg = rt;
	assign ret_data = wb_data;

endmodule

`default_nettype wire

// File: reg_file.sv
`default_nettype none

module reg_file (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic we,
	input wire cpu_pkg::reg_idx_t wa,
	input wire cpu_pkg::reg_idx_t ra_idx,
	input wire cpu_pkg::reg_idx_t rb_idx,
	input wire cpu_pkg::reg_idx_t rt_idx,
	input wire cpu_pkg::word_t wd,
	output cpu_pkg::word_t ra_data,
	output cpu_pkg::word_t rb_data,
	output cpu_pkg::word_t rt_data
);

	import cpu_pkg::*;

	word_t regs [32];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wa != '0) begin
			regs[wa] <= wd; // r0 stays zero.
		end
	end

	assign ra_data = (ra_idx == '0) ? '0 : regs[ra_idx];
	assign rb_data = (rb_idx == '0) ? '0 : regs[rb_idx];
	assign rt_data = (rt_idx == '0) ? '0 : regs[rt_idx];

endmodule

`default_nettype wire

// File: alu.sv
`default_nettype none

module alu (
	input wire cpu_pkg::word_t a,
	input wire cpu_pkg::word_t b,
	input wire cpu_pkg::alu_op_t op,
	output cpu_pkg::word_t result,
	output logic zero
);

	import cpu_pkg::*;

	always_comb begin
		case (op)
			ALU_ADD: begin
				result = a + b;
			end
			ALU_SUB: begin
				result = a - b;
			end
			ALU_AND: begin
				result = a & b;
			end
			ALU_OR: begin
				result = a | b;
			end
			ALU_XOR: begin
				result = a ^ b;
			end
			ALU_SLL: begin
				result = a << b[4:0]; // low five bits only.
			end
			default: begin
				result = '0;
			end
		endcase
	end

	assign zero = (result == '0);

endmodule

`default_nettype wire

// File: decoder.sv
`default_nettype none

module decoder (
	input wire cpu_pkg::word_t instr,
	output cpu_pkg::ctrl_t ctrl,
	output cpu_pkg::reg_idx_t rt,
	output cpu_pkg::reg_idx_t ra,
	output cpu_pkg::reg_idx_t rb
);

	import cpu_pkg::*;

	op_t op;

	assign op = op_t'(instr[OP_HI:OP_LO]);
	assign rt = instr[RT_HI:RT_LO];
	assign ra = instr[RA_HI:RA_LO];
	assign rb = instr[RB_HI:RB_LO];

	always_comb begin
		ctrl = CTRL_NOP; // unknown opcodes only advance pc.
		case (op)
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
				ctrl.sel_src2 = SEL_SRC2_RB;
				ctrl.reg_write = 1'b1;
				case (op)
					OP_SUB: ctrl.alu_op = ALU_SUB;
					OP_AND: ctrl.alu_op = ALU_AND;
					OP_OR: ctrl.alu_op = ALU_OR;
					OP_XOR: ctrl.alu_op = ALU_XOR;
					default: ctrl.alu_op = ALU_ADD;
				endcase
			end
			OP_SLLI: begin
				ctrl.sel_src2 = SEL_SRC2_IMM;
				ctrl.sel_ext = SEL_EXT_ZE5;
				ctrl.alu_op = ALU_SLL;
				ctrl.reg_write = 1'b1;
			end
			OP_ADDI: begin
				ctrl.sel_src2 = SEL_SRC2_IMM;
				ctrl.sel_ext = SEL_EXT_SE15;
				ctrl.alu_op = ALU_ADD;
				ctrl.reg_write = 1'b1;
			end
			OP_ORI: begin
				ctrl.sel_src2 = SEL_SRC2_IMM;
				ctrl.sel_ext = SEL_EXT_ZE15;
				ctrl.alu_op = ALU_OR;
				ctrl.reg_write = 1'b1;
			end
			OP_MOVI: begin
				ctrl.sel_src2 = SEL_SRC2_IMM;
				ctrl.sel_ext = SEL_EXT_SE20;
				ctrl.sel_wb = SEL_WB_SRC2; // bypasses the alu.
				ctrl.reg_write = 1'b1;
			end
			OP_LWI: begin
				ctrl.sel_src2 = SEL_SRC2_IMM15_SL2;
				ctrl.alu_op = ALU_ADD;
				ctrl.sel_wb = SEL_WB_MEM;
				ctrl.mem_read = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			OP_SWI: begin
				ctrl.sel_src2 = SEL_SRC2_IMM15_SL2;
				ctrl.alu_op = ALU_ADD;
				ctrl.mem_write = 1'b1; // store data is rt.
			end
			OP_LW: begin
				ctrl.sel_src2 = SEL_SRC2_RB_SV;
				ctrl.alu_op = ALU_ADD;
				ctrl.sel_wb = SEL_WB_MEM;
				ctrl.mem_read = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			OP_BEQ: begin
				ctrl.sel_src2 = SEL_SRC2_RT;
				ctrl.alu_op = ALU_SUB; // zero when ra equals rt.
				ctrl.sel_pc = SEL_PC_BRANCH;
				ctrl.branch = 1'b1;
			end
			OP_J: begin
				ctrl.sel_pc = SEL_PC_JUMP;
			end
			default: begin
				ctrl = CTRL_NOP;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: muxs.sv
`default_nettype none

module muxs (
	input wire cpu_pkg::pc_t current_pc,
	input wire cpu_pkg::sv_t sub_op_sv,
	input wire cpu_pkg::word_t reg_rb_data,
	input wire cpu_pkg::word_t reg_rt_data,
	input wire cpu_pkg::word_t mem_read_data,
	input wire cpu_pkg::word_t alu_output,
	input wire logic [4:0] imm_5bit,
	input wire logic [13:0] imm_14bit,
	input wire logic [14:0] imm_15bit,
	input wire logic [19:0] imm_20bit,
	input wire logic [23:0] imm_24bit,
	input wire cpu_pkg::sel_pc_t select_pc,
	input wire cpu_pkg::sel_src2_t select_alu_src2,
	input wire cpu_pkg::sel_ext_t select_imm_extend,
	input wire cpu_pkg::sel_wb_t select_write_reg,
	output cpu_pkg::pc_t next_pc,
	output cpu_pkg::word_t output_imm_reg_mux,
	output cpu_pkg::word_t write_reg_data
);

	import cpu_pkg::*;

	word_t imm;
	pc_t branch_off;
	pc_t jump_off;

	// ========================================
	// next pc
	// ========================================
	assign branch_off = {imm_14bit[13], imm_14bit[7:0], 1'b0};
	assign jump_off = {imm_24bit[23], imm_24bit[7:0], 1'b0};

	always_comb begin
		case (select_pc)
			SEL_PC_BRANCH: begin
				next_pc = current_pc + branch_off; // wraps at 10 bits.
			end
			SEL_PC_JUMP: begin
				next_pc = current_pc + jump_off;
			end
			default: begin
				next_pc = current_pc + PC_STEP;
			end
		endcase
	end

	// ========================================
	// immediate and operand select
	// ========================================
	always_comb begin
		case (select_imm_extend)
			SEL_EXT_ZE5: begin
				imm = {27'b0, imm_5bit}; // shift amount.
			end
			SEL_EXT_SE15: begin
				imm = {{17{imm_15bit[14]}}, imm_15bit};
			end
			SEL_EXT_ZE15: begin
				imm = {17'b0, imm_15bit};
			end
			default: begin
				imm = {{12{imm_20bit[19]}}, imm_20bit};
			end
		endcase
	end

	always_comb begin
		case (select_alu_src2)
			SEL_SRC2_IMM: begin
				output_imm_reg_mux = imm;
			end
			SEL_SRC2_IMM15_SL2: begin
				output_imm_reg_mux = {{15{imm_15bit[14]}}, imm_15bit, 2'b00}; // word offset.
			end
			SEL_SRC2_RB_SV: begin
				output_imm_reg_mux = reg_rb_data << sub_op_sv;
			end
			SEL_SRC2_RT: begin
				output_imm_reg_mux = reg_rt_data; // compare operand.
			end
			default: begin
				output_imm_reg_mux = reg_rb_data;
			end
		endcase
	end

	always_comb begin
		case (select_write_reg)
			SEL_WB_SRC2: begin
				write_reg_data = output_imm_reg_mux; // movi path.
			end
			SEL_WB_MEM: begin
				write_reg_data = mem_read_data;
			end
			default: begin
				write_reg_data = alu_output;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	// ========================================
	// widths and types
	// ========================================
	localparam int WORD_W = 32;
	localparam int PC_W = 10;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [PC_W-1:0] pc_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [1:0] sv_t;

	localparam pc_t PC_STEP = 10'd4;

	// instruction field positions.
	localparam int OP_HI = 31;
	localparam int OP_LO = 26;
	localparam int RT_HI = 25;
	localparam int RT_LO = 21;
	localparam int RA_HI = 20;
	localparam int RA_LO = 16;
	localparam int RB_HI = 15;
	localparam int RB_LO = 11;
	localparam int SV_HI = 9;
	localparam int SV_LO = 8;
	localparam int IMM5_HI = 14;
	localparam int IMM5_LO = 10;
	localparam int IMM14_HI = 13;
	localparam int IMM15_HI = 14;
	localparam int IMM20_HI = 19;
	localparam int IMM24_HI = 23;

	// ========================================
	// opcodes and control
	// ========================================
	typedef enum logic [5:0] {
		OP_ADD  = 6'h00,
		OP_SUB  = 6'h01,
		OP_AND  = 6'h02,
		OP_OR   = 6'h03,
		OP_XOR  = 6'h04,
		OP_SLLI = 6'h08,
		OP_ADDI = 6'h10,
		OP_ORI  = 6'h11,
		OP_MOVI = 6'h12,
		OP_LWI  = 6'h20,
		OP_SWI  = 6'h21,
		OP_LW   = 6'h22,
		OP_BEQ  = 6'h30,
		OP_J    = 6'h38
	} op_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL
	} alu_op_t;

	typedef logic [1:0] sel_pc_t;
	localparam sel_pc_t SEL_PC_SEQ = 2'b00;
	localparam sel_pc_t SEL_PC_BRANCH = 2'b01;
	localparam sel_pc_t SEL_PC_JUMP = 2'b10;

	typedef logic [2:0] sel_src2_t;
	localparam sel_src2_t SEL_SRC2_RB = 3'b000;
	localparam sel_src2_t SEL_SRC2_IMM = 3'b001;
	localparam sel_src2_t SEL_SRC2_IMM15_SL2 = 3'b010;
	localparam sel_src2_t SEL_SRC2_RB_SV = 3'b011;
	localparam sel_src2_t SEL_SRC2_RT = 3'b100;

	typedef logic [1:0] sel_ext_t;
	localparam sel_ext_t SEL_EXT_ZE5 = 2'b00;
	localparam sel_ext_t SEL_EXT_SE15 = 2'b01;
	localparam sel_ext_t SEL_EXT_ZE15 = 2'b10;
	localparam sel_ext_t SEL_EXT_SE20 = 2'b11;

	typedef logic [1:0] sel_wb_t;
	localparam sel_wb_t SEL_WB_ALU = 2'b00;
	localparam sel_wb_t SEL_WB_SRC2 = 2'b01;
	localparam sel_wb_t SEL_WB_MEM = 2'b10;

	typedef struct packed {
		sel_pc_t   sel_pc;
		sel_src2_t sel_src2;
		sel_ext_t  sel_ext;
		sel_wb_t   sel_wb;
		alu_op_t   alu_op;
		logic      reg_write;
		logic      mem_read;
		logic      mem_write;
		logic      branch; // taken only when alu zero is set.
	} ctrl_t;

	localparam ctrl_t CTRL_NOP = '{
		sel_pc:    SEL_PC_SEQ,
		sel_src2:  SEL_SRC2_RB,
		sel_ext:   SEL_EXT_ZE5,
		sel_wb:    SEL_WB_ALU,
		alu_op:    ALU_ADD,
		reg_write: 1'b0,
		mem_read:  1'b0,
		mem_write: 1'b0,
		branch:    1'b0
	};

endpackage

`default_nettype wire
